//--- verilog/k005885_timing_pkg.sv
// Video timing definitions
package k005885_timing_pkg;

	// Beam position types, wide enough for 384 pixels and 262 lines
	typedef logic [8:0] hcount_t;
	typedef logic [8:0] vcount_t;

	// Screen centering value as driven on the hctr and vctr pins
	typedef logic [3:0] center_t;

	// ====================
	// Frame geometry
	localparam hcount_t H_TOTAL = 9'd384;
	localparam vcount_t V_LAST = 9'd261;

	// Blanking windows, horizontal positions are tested on every pixel
	localparam hcount_t HBLANK_END = 9'd13;
	localparam hcount_t HBLANK_START_NARROW = 9'd253;
	localparam hcount_t HBLANK_START_WIDE = 9'd293;
	// Vertical positions are tested on the last pixel of a line
	localparam vcount_t VBLANK_END = 9'd15;
	localparam vcount_t VBLANK_START = 9'd239;

	// ====================
	// Sync windows before any centering shift
	localparam hcount_t HSYNC_START_NARROW = 9'd296;
	localparam hcount_t HSYNC_END_NARROW = 9'd327;
	localparam hcount_t HSYNC_START_WIDE = 9'd320;
	localparam hcount_t HSYNC_END_WIDE = 9'd351;
	// Pulled off both bounds when centering moves the sync earlier
	localparam hcount_t HSYNC_EARLY = 9'd8;
	localparam vcount_t VSYNC_START = 9'd254;
	localparam vcount_t VSYNC_END = 9'd261;

	// Video state that the interrupt logic samples
	typedef struct packed {
		logic hblank;
		logic vblank;
		logic frame_odd;
		vcount_t vcount;
	} video_status_t;

endpackage

//--- verilog/k005885_cpu_pkg.sv
// CPU interface definitions
package k005885_cpu_pkg;

	// Address and data widths of the MC6809E side
	typedef logic [13:0] cpu_addr_t;
	typedef logic [7:0] cpu_data_t;
	typedef logic [2:0] reg_offset_t;

	// CPU bus as seen at the chip pins, strobes are active low
	typedef struct packed {
		logic nxcs;
		logic nrd;
		cpu_addr_t addr;
		cpu_data_t data;
	} cpu_bus_t;

	// ====================
	// Register offsets within the control block
	localparam reg_offset_t REG_TILE_CTRL = 3'd3;
	localparam reg_offset_t REG_IRQ_CTRL = 3'd4;

	// The control block sits where address bits 13..11 are zero
	localparam logic [2:0] REG_BLOCK_HI = 3'b000;
	// and address bits 6..3 are zero as well
	localparam logic [3:0] REG_BLOCK_MID = 4'd0;
	// NIOC goes low for external I/O at address bits 13..11 of 001
	localparam logic [2:0] NIOC_BLOCK = 3'b001;

	// Control bits kept from the register block
	typedef struct packed {
		logic wide_mode;
		logic nmi_en;
		logic irq_en;
		logic firq_en;
	} ctrl_t;

endpackage

//--- verilog/k005885_clocks.sv
// Clock divider and CPU clocks
`timescale 1ns/1ps

module k005885_clocks (
	input logic CK49,
	input logic rst_n,
	output logic cen_6m,
	output logic cen_3m,
	output logic nck2,
	output logic h1o,
	output logic ncpe,
	output logic ncpq,
	output logic neq
);

	// Free-running divider of the 49.152 MHz master clock
	logic [3:0] div;
	// Quarter-phase position of the MC6809E clock pair
	logic [1:0] phase;

	always_ff @(posedge CK49) begin
		if (!rst_n) begin
			div <= 4'd0;
		end else begin
			div <= div + 4'd1;
		end
	end

	// Pixel enable at 6.144 MHz and CPU enable at 3.072 MHz
	assign cen_6m = (div[2:0] == 3'd0);
	assign cen_3m = (div == 4'd0);

	// Divided clocks go straight out from the divider bits
	assign nck2 = div[2];
	assign h1o = div[3];

	// ====================
	// E and Q toggle on alternate quarters, Q a quarter behind E
	always_ff @(posedge CK49) begin
		if (!rst_n) begin
			phase <= 2'd0;
			ncpe <= 1'b0;
			ncpq <= 1'b0;
		end else if (cen_6m) begin
			phase <= phase + 2'd1;
			case (phase)
				2'd0: ncpq <= 1'b0;
				2'd1: ncpe <= 1'b1;
				2'd2: ncpq <= 1'b1;
				default: ncpe <= 1'b0;
			endcase
		end
	end

	// Both clocks high together for the external AND output
	assign neq = ncpe & ncpq;

endmodule

//--- verilog/k005885_video_timing.sv
// Video counters and sync generation
`timescale 1ns/1ps

module k005885_video_timing
	import k005885_timing_pkg::*;
	import k005885_cpu_pkg::*;
(
	input logic CK49,
	input logic rst_n,
	input logic cen_6m,
	input ctrl_t ctrl,
	input center_t hctr,
	input center_t vctr,
	output video_status_t status,
	output logic hblk,
	output logic vblk,
	output logic nhsy,
	output logic nvsy,
	output logic ncsy
);

	hcount_t h_cnt;
	vcount_t v_cnt;
	logic hblank;
	logic vblank;
	logic frame_odd;

	// Horizontal sync bounds after mode select and the coarse early step
	hcount_t hs_start;
	hcount_t hs_end;
	hcount_t hs_early;
	hcount_t hs_late_shift;
	hcount_t hs_early_shift;
	hcount_t hs_lo;
	hcount_t hs_hi;
	vcount_t vs_lo;
	vcount_t vs_hi;

	// ====================
	// Beam counters and blanking
	always_ff @(posedge CK49) begin
		if (!rst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
			hblank <= 1'b0;
			vblank <= 1'b0;
			frame_odd <= 1'b0;
		end else if (cen_6m) begin
			// HBlank ends early in the line and starts later in wide mode
			if (h_cnt == HBLANK_END) begin
				hblank <= 1'b0;
			end
			if (h_cnt == (ctrl.wide_mode ? HBLANK_START_WIDE : HBLANK_START_NARROW)) begin
				hblank <= 1'b1;
			end
			if (h_cnt == H_TOTAL - 9'd1) begin
				h_cnt <= '0;
				// Vertical events happen at the end of the line
				if (v_cnt == VBLANK_END) begin
					vblank <= 1'b0;
				end
				if (v_cnt == VBLANK_START) begin
					vblank <= 1'b1;
					frame_odd <= ~frame_odd;
				end
				if (v_cnt == V_LAST) begin
					v_cnt <= '0;
				end else begin
					v_cnt <= v_cnt + 9'd1;
				end
			end else begin
				h_cnt <= h_cnt + 9'd1;
			end
		end
	end

	// ====================
	// Sync window selection, registered so a mode change takes one cycle
	assign hs_early = hctr[3] ? HSYNC_EARLY : 9'd0;

	always_ff @(posedge CK49) begin
		if (!rst_n) begin
			hs_start <= HSYNC_START_NARROW;
			hs_end <= HSYNC_END_NARROW;
		end else begin
			hs_start <= (ctrl.wide_mode ? HSYNC_START_WIDE : HSYNC_START_NARROW) - hs_early;
			hs_end <= (ctrl.wide_mode ? HSYNC_END_WIDE : HSYNC_END_NARROW) - hs_early;
		end
	end

	// Fine centering moves later by hctr[2:0] or earlier by its complement
	assign hs_late_shift = {6'd0, hctr[2:0]};
	assign hs_early_shift = {6'd0, ~hctr[2:0]};
	assign hs_lo = hctr[3] ? hs_start - hs_early_shift : hs_start + hs_late_shift;
	assign hs_hi = hctr[3] ? hs_end - hs_early_shift : hs_end + hs_late_shift;

	// Vertical centering only ever pulls the sync earlier
	assign vs_lo = VSYNC_START - {5'd0, vctr};
	assign vs_hi = VSYNC_END - {5'd0, vctr};

	// Syncs are active low and decoded straight from the counters
	assign nhsy = ~((h_cnt >= hs_lo) && (h_cnt <= hs_hi));
	assign nvsy = ~((v_cnt >= vs_lo) && (v_cnt <= vs_hi));
	assign ncsy = nhsy ^ nvsy;

	assign hblk = hblank;
	assign vblk = vblank;

	assign status = '{hblank: hblank, vblank: vblank, frame_odd: frame_odd, vcount: v_cnt};

endmodule

//--- verilog/k005885_ctrl_regs.sv
// Control register block
`timescale 1ns/1ps

module k005885_ctrl_regs
	import k005885_cpu_pkg::*;
(
	input logic CK49,
	input logic rst_n,
	input logic cen_3m,
	input cpu_bus_t bus,
	output ctrl_t ctrl,
	output logic nioc
);

	logic reg_sel;
	logic reg_wr;
	reg_offset_t offset;

	// The register block decodes on the upper and middle address bits
	assign reg_sel = ~bus.nxcs
		&& (bus.addr[13:11] == REG_BLOCK_HI)
		&& (bus.addr[6:3] == REG_BLOCK_MID);

	// Writes land on the CPU enable while nrd is high
	assign reg_wr = reg_sel & bus.nrd & cen_3m;
	assign offset = bus.addr[2:0];

	// ====================
	// Only the wide mode bit and the interrupt enables are kept
	always_ff @(posedge CK49) begin
		if (!rst_n) begin
			ctrl <= '0;
		end else if (reg_wr) begin
			case (offset)
				REG_TILE_CTRL: begin
					// Bit 2 widens the display to 280 pixels
					ctrl.wide_mode <= bus.data[2];
				end
				REG_IRQ_CTRL: begin
					ctrl.nmi_en <= bus.data[0];
					ctrl.irq_en <= bus.data[1];
					ctrl.firq_en <= bus.data[2];
				end
				default: begin
					// Scroll and other registers are not modelled
					ctrl <= ctrl;
				end
			endcase
		end
	end

	// External I/O decode, low while selected in the 0x0800 block
	assign nioc = ~(~bus.nxcs && (bus.addr[13:11] == NIOC_BLOCK));

endmodule

//--- verilog/k005885_irq.sv
// Interrupt generation
`timescale 1ns/1ps

module k005885_irq
	import k005885_timing_pkg::*;
	import k005885_cpu_pkg::*;
(
	input logic CK49,
	input logic rst_n,
	input video_status_t status,
	input ctrl_t ctrl,
	output logic nirq,
	output logic nfir,
	output logic nnmi
);

	// Previous values for edge detection
	logic old_vblank;
	logic old_v4;
	logic old_v5;
	logic vblank_rise;
	logic nmi_event;

	always_ff @(posedge CK49) begin
		if (!rst_n) begin
			old_vblank <= 1'b0;
			old_v4 <= 1'b0;
			old_v5 <= 1'b0;
		end else begin
			old_vblank <= status.vblank;
			old_v4 <= status.vcount[4];
			old_v5 <= status.vcount[5];
		end
	end

	assign vblank_rise = ~old_vblank & status.vblank;

	// NMI every 64 lines, or every 32 lines in wide mode
	assign nmi_event = ctrl.wide_mode ? (old_v4 & ~status.vcount[4])
		: (old_v5 & ~status.vcount[5]);

	// ====================
	// Each line latches low and is released only by clearing its enable
	always_ff @(posedge CK49) begin
		if (!rst_n || !ctrl.irq_en) begin
			nirq <= 1'b1;
		end else if (vblank_rise) begin
			nirq <= 1'b0;
		end
	end

	// Frame parity has already toggled when VBlank rises
	always_ff @(posedge CK49) begin
		if (!rst_n || !ctrl.firq_en) begin
			nfir <= 1'b1;
		end else if (vblank_rise && status.frame_odd) begin
			nfir <= 1'b0;
		end
	end

	always_ff @(posedge CK49) begin
		if (!rst_n || !ctrl.nmi_en) begin
			nnmi <= 1'b1;
		end else if (nmi_event) begin
			nnmi <= 1'b0;
		end
	end

endmodule

//--- verilog/k005885.sv
// Konami 005885 timing core
`timescale 1ns/1ps

module k005885
	import k005885_timing_pkg::*;
	import k005885_cpu_pkg::*;
(
	input logic CK49,
	input logic rst_n,
	input logic nrd,
	input logic nxcs,
	input cpu_addr_t a,
	input cpu_data_t dbi,
	input center_t hctr,
	input center_t vctr,
	output logic nck2,
	output logic h1o,
	output logic ncpe,
	output logic ncpq,
	output logic neq,
	output logic hblk,
	output logic vblk,
	output logic nhsy,
	output logic nvsy,
	output logic ncsy,
	output logic nirq,
	output logic nfir,
	output logic nnmi,
	output logic nioc
);

	logic cen_6m;
	logic cen_3m;
	cpu_bus_t bus;
	ctrl_t ctrl;
	video_status_t status;

	// Gather the CPU pins into one bus
	assign bus = '{nxcs: nxcs, nrd: nrd, addr: a, data: dbi};

	// ====================
	// Clock enables and the MC6809E clock pair
	k005885_clocks u_clocks (
		.CK49(CK49),
		.rst_n(rst_n),
		.cen_6m(cen_6m),
		.cen_3m(cen_3m),
		.nck2(nck2),
		.h1o(h1o),
		.ncpe(ncpe),
		.ncpq(ncpq),
		.neq(neq)
	);

	k005885_ctrl_regs u_ctrl_regs (
		.CK49(CK49),
		.rst_n(rst_n),
		.cen_3m(cen_3m),
		.bus(bus),
		.ctrl(ctrl),
		.nioc(nioc)
	);

	// Beam counters, blanking and syncs
	k005885_video_timing u_video_timing (
		.CK49(CK49),
		.rst_n(rst_n),
		.cen_6m(cen_6m),
		.ctrl(ctrl),
		.hctr(hctr),
		.vctr(vctr),
		.status(status),
		.hblk(hblk),
		.vblk(vblk),
		.nhsy(nhsy),
		.nvsy(nvsy),
		.ncsy(ncsy)
	);

	k005885_irq u_irq (
		.CK49(CK49),
		.rst_n(rst_n),
		.status(status),
		.ctrl(ctrl),
		.nirq(nirq),
		.nfir(nfir),
		.nnmi(nnmi)
	);

endmodule

//--- sim/k005885_properties.sv
// Timing core output properties
`timescale 1ns/1ps

module k005885_properties (
	input logic CK49,
	input logic rst_n,
	input logic ncpe,
	input logic ncpq,
	input logic neq,
	input logic nhsy,
	input logic nvsy,
	input logic ncsy,
	input logic vblk,
	input logic nirq,
	input logic nfir,
	input logic nnmi
);

	// NEQ is high only while both CPU clocks are high
	assert property (@(posedge CK49) disable iff (!rst_n) neq == (ncpe & ncpq))
		else $error("neq differs from ncpe AND ncpq");

	// Composite sync mixes the two sync pulses
	assert property (@(posedge CK49) disable iff (!rst_n) ncsy == (nhsy ^ nvsy))
		else $error("ncsy differs from nhsy XOR nvsy");

	// All interrupt lines are released by reset
	assert property (@(posedge CK49) !rst_n |=> (nirq && nfir && nnmi))
		else $error("interrupt line low during reset");

	// A fresh IRQ needs VBlank to have risen in the cycle before
	assert property (@(posedge CK49) disable iff (!rst_n)
		(!nirq && $past(nirq)) |-> ($past(vblk) && !$past(vblk, 2)))
		else $error("nirq fell without a VBlank rise");

endmodule

//--- sim/tb_k005885.sv
// Timing core testbench
`timescale 1ns/1ps

module tb_k005885
	import k005885_timing_pkg::*;
	import k005885_cpu_pkg::*;
();

	// Expected video levels for one pixel
	typedef struct packed {
		logic hblk;
		logic vblk;
		logic nhsy;
		logic nvsy;
		logic ncsy;
	} video_exp_t;

	// The three interrupt outputs as one set
	typedef struct packed {
		logic nirq;
		logic nfir;
		logic nnmi;
	} irq_set_t;

	// Four frames of 804864 cycles plus margin
	localparam int CYCLE_LIMIT = 4000000;

	logic CK49;
	logic rst_n;
	logic nrd;
	logic nxcs;
	cpu_addr_t a;
	cpu_data_t dbi;
	center_t hctr;
	center_t vctr;
	logic nck2, h1o, ncpe, ncpq, neq;
	logic hblk, vblk, nhsy, nvsy, ncsy;
	logic nirq, nfir, nnmi, nioc;

	int seed;
	int rnd;
	int n;
	int cycles;
	int checks;
	int level_errors;
	int sync_errors;
	int irq_errors;
	logic wr_active;
	logic wr_hit;
	ctrl_t ctrl_exp;
	irq_set_t irq_exp;

	k005885 u_dut (
		.CK49(CK49), .rst_n(rst_n), .nrd(nrd), .nxcs(nxcs), .a(a), .dbi(dbi),
		.hctr(hctr), .vctr(vctr), .nck2(nck2), .h1o(h1o), .ncpe(ncpe), .ncpq(ncpq),
		.neq(neq), .hblk(hblk), .vblk(vblk), .nhsy(nhsy), .nvsy(nvsy), .ncsy(ncsy),
		.nirq(nirq), .nfir(nfir), .nnmi(nnmi), .nioc(nioc)
	);

	bind k005885 k005885_properties u_properties (
		.CK49(CK49), .rst_n(rst_n), .ncpe(ncpe), .ncpq(ncpq), .neq(neq),
		.nhsy(nhsy), .nvsy(nvsy), .ncsy(ncsy), .vblk(vblk),
		.nirq(nirq), .nfir(nfir), .nnmi(nnmi)
	);

	// 50 MHz stand-in for the 49.152 MHz master clock
	always #10 CK49 = ~CK49;

	// ====================
	// Expected blank and sync levels from the beam position and settings
	function automatic video_exp_t ref_video(input int pix, input logic wide,
		input center_t hc, input center_t vc);
		video_exp_t r;
		int h;
		int line;
		int v;
		int hs_lo;
		int vs_lo;
		h = pix % 384;
		line = pix / 384;
		v = line % 262;
		hs_lo = wide ? 320 : 296;
		// Bit 3 pulls the pulse earlier, the low bits push it later
		if (hc[3]) begin
			hs_lo = hs_lo - 8 - (7 - int'(hc[2:0]));
		end else begin
			hs_lo = hs_lo + int'(hc[2:0]);
		end
		vs_lo = 254 - int'(vc);
		// Blanks start low after reset until their first falling point
		r.hblk = (pix >= 14) && ((h > (wide ? 293 : 253)) || (h <= 13));
		r.vblk = (line >= 16) && ((v > 239) || (v <= 15));
		r.nhsy = !((h >= hs_lo) && (h <= hs_lo + 31));
		r.nvsy = !((v >= vs_lo) && (v <= vs_lo + 7));
		r.ncsy = r.nhsy ^ r.nvsy;
		return r;
	endfunction

	task automatic check_level(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			level_errors++;
			$display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_sync(input string name, input center_t ctr, input int pos,
		input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			sync_errors++;
			$display("MISMATCH at %0t: %s is %b, expected %b at position %0d with centering %h",
				$time, name, got, exp, pos, ctr);
		end
	endtask

	task automatic check_irq(input irq_set_t got, input irq_set_t exp);
		checks++;
		if (got !== exp) begin
			irq_errors++;
			$display("MISMATCH at %0t: nirq/nfir/nnmi are %b, expected %b", $time, got, exp);
		end
	endtask

	// One CPU write held for 16 cycles, so that exactly one CPU enable sees it
	task automatic cpu_write(input cpu_addr_t addr, input cpu_data_t data,
		input logic cs_n, input logic hit);
		int gap;
		gap = $random(seed) & 15;
		repeat (gap) @(posedge CK49);
		// Mode changes land mid line, well away from blank and sync edges
		while ((((n + 7) / 8) % 384 < 20) || (((n + 7) / 8) % 384 > 150)) begin
			@(posedge CK49);
		end
		nxcs <= cs_n;
		nrd <= 1'b1;
		a <= addr;
		dbi <= data;
		wr_active <= 1'b1;
		wr_hit <= hit;
		repeat (16) @(posedge CK49);
		nxcs <= 1'b1;
		wr_active <= 1'b0;
	endtask

	// ====================
	// Reference model, n counts clock edges since reset was released
	always @(posedge CK49) begin : reference
		int pix;
		int line;
		int v;
		int v_prev;
		int bit_sel;
		logic line_start;
		logic vbl_rise;
		logic odd_frame;
		logic nmi_ev;
		if (!rst_n) begin
			n <= 0;
			ctrl_exp <= '0;
			irq_exp <= '1;
		end else begin
			pix = (n + 7) / 8;
			line = pix / 384;
			v = line % 262;
			v_prev = (v == 0) ? 261 : v - 1;
			bit_sel = ctrl_exp.wide_mode ? 4 : 5;
			// First clock of pixel 0 on a new line
			line_start = (n % 8 == 1) && (pix % 384 == 0);
			vbl_rise = line_start && (v == 240);
			odd_frame = ((line / 262) % 2) == 0;
			nmi_ev = line_start && v_prev[bit_sel] && !v[bit_sel];
			irq_exp.nirq <= ctrl_exp.irq_en ? (irq_exp.nirq & ~vbl_rise) : 1'b1;
			irq_exp.nfir <= ctrl_exp.firq_en ? (irq_exp.nfir & ~(vbl_rise & odd_frame)) : 1'b1;
			irq_exp.nnmi <= ctrl_exp.nmi_en ? (irq_exp.nnmi & ~nmi_ev) : 1'b1;
			// A register write takes effect on the CPU enable cycle
			if (wr_active && wr_hit && (n % 16 == 0)) begin
				if (a[2:0] == REG_TILE_CTRL) begin
					ctrl_exp.wide_mode <= dbi[2];
				end
				if (a[2:0] == REG_IRQ_CTRL) begin
					ctrl_exp.nmi_en <= dbi[0];
					ctrl_exp.irq_en <= dbi[1];
					ctrl_exp.firq_en <= dbi[2];
				end
			end
			n <= n + 1;
		end
	end

	// Outputs are compared on the falling edge, half a cycle after they settle
	always @(negedge CK49) begin : compare
		video_exp_t ev;
		irq_set_t got;
		int pix;
		int phase;
		logic e_exp;
		logic q_exp;
		if (rst_n) begin
			pix = (n + 7) / 8;
			phase = pix % 4;
			// E leads Q by a quarter and both start low
			e_exp = (phase >= 2);
			q_exp = (phase == 3) || ((phase == 0) && (pix > 0));
			ev = ref_video(pix, ctrl_exp.wide_mode, hctr, vctr);
			got = {nirq, nfir, nnmi};
			check_level("nck2", nck2, n[2]);
			check_level("h1o", h1o, n[3]);
			check_level("ncpe", ncpe, e_exp);
			check_level("ncpq", ncpq, q_exp);
			check_level("neq", neq, e_exp & q_exp);
			check_level("hblk", hblk, ev.hblk);
			check_level("vblk", vblk, ev.vblk);
			check_level("nioc", nioc, nxcs || (a[13:11] != 3'b001));
			check_sync("nhsy", hctr, pix % 384, nhsy, ev.nhsy);
			check_sync("nvsy", vctr, (pix / 384) % 262, nvsy, ev.nvsy);
			check_level("ncsy", ncsy, ev.ncsy);
			check_irq(got, irq_exp);
		end
	end

	// Watchdog on the whole run
	always @(posedge CK49) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	// ====================
	initial begin
		seed = 54206;
		CK49 = 1'b0;
		rst_n = 1'b0;
		nrd = 1'b1;
		nxcs = 1'b1;
		a = '0;
		dbi = '0;
		wr_active = 1'b0;
		wr_hit = 1'b0;
		cycles = 0;
		checks = 0;
		level_errors = 0;
		sync_errors = 0;
		irq_errors = 0;
		rnd = $random(seed);
		hctr = rnd[3:0];
		rnd = $random(seed);
		vctr = rnd[3:0];
		repeat (4) @(posedge CK49);
		rst_n <= 1'b1;
		// Writes that must leave the control bits alone
		cpu_write(14'h0003, 8'h04, 1'b1, 1'b0);
		cpu_write(14'h0803, 8'h04, 1'b0, 1'b0);
		cpu_write(14'h2003, 8'h04, 1'b0, 1'b0);
		cpu_write(14'h000b, 8'h04, 1'b0, 1'b0);
		cpu_write(14'h0005, 8'hff, 1'b0, 1'b1);
		cpu_write(14'h0004, 8'h07, 1'b0, 1'b1);
		// First VBlank is on an odd frame
		@(posedge vblk);
		// Release FIRQ and NMI while IRQ keeps holding
		cpu_write(14'h0004, 8'h02, 1'b0, 1'b1);
		cpu_write(14'h0004, 8'h07, 1'b0, 1'b1);
		@(posedge vblk);
		// Fully masked through the next VBlank
		cpu_write(14'h0004, 8'h00, 1'b0, 1'b1);
		@(posedge vblk);
		cpu_write(14'h0004, 8'h07, 1'b0, 1'b1);
		cpu_write(14'h0003, 8'h04, 1'b0, 1'b1);
		@(posedge vblk);
		// Re-arm NMI at line 16, the wide mode event then comes at line 32
		@(negedge vblk);
		cpu_write(14'h0004, 8'h06, 1'b0, 1'b1);
		cpu_write(14'h0004, 8'h07, 1'b0, 1'b1);
		// Stop past line 32 and well short of line 64
		repeat (24) @(posedge hblk);
		$display("Checks run: %0d, level errors: %0d, sync errors: %0d, irq errors: %0d",
			checks, level_errors, sync_errors, irq_errors);
		if ((level_errors + sync_errors + irq_errors) == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- k005885.f
verilog/k005885_timing_pkg.sv
verilog/k005885_cpu_pkg.sv
verilog/k005885_clocks.sv
verilog/k005885_video_timing.sv
verilog/k005885_ctrl_regs.sv
verilog/k005885_irq.sv
verilog/k005885.sv
sim/k005885_properties.sv
sim/tb_k005885.sv

//--- run_sim.sh
#!/bin/sh
# Build the k005885 testbench with Verilator, run it and scan the log
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module tb_k005885 -f k005885.f -o Vtb_k005885 \
	&& ./obj_dir/Vtb_k005885 > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
exit 0
